// ==== verilog/limiter_params.svh ====
// Stream limiter parameters
// Sample, bus address and clip counter widths
// Register bus base address and register offsets

`ifndef LIMITER_PARAMS_SVH
`define LIMITER_PARAMS_SVH

// Sample and limit width
`define LIM_DATA_WIDTH 32

// Register bus address width
`define LIM_ADDR_WIDTH 32

// Clip counter width
`define LIM_COUNT_WIDTH 16

// Register bus base address
`define LIM_BASE_ADDRESS 32'h43c0_0000

// Register offsets from the base address
`define LIM_REG_UPPER     32'h0000_0000
`define LIM_REG_LOWER     32'h0000_0004
`define LIM_REG_CLIP_HIGH 32'h0000_0008
`define LIM_REG_CLIP_LOW  32'h0000_000C

`endif

// ==== verilog/limiter_pkg.sv ====
// Shared types of the stream limiter
// Sample, bus address, bus data and clip counter vectors
// Register bus state machine encoding

`include "limiter_params.svh"

package limiter_pkg;

    // One sample or one limit
    typedef logic [`LIM_DATA_WIDTH-1:0] sample_t;

    // Absolute register bus address
    typedef logic [`LIM_ADDR_WIDTH-1:0] bus_addr_t;

    // Register bus data word
    typedef logic [31:0] bus_data_t;

    // Saturating clip event counter
    typedef logic [`LIM_COUNT_WIDTH-1:0] clip_count_t;

    // Register bus handshake states
    typedef enum logic {
        IDLE,
        ACT
    } bus_state_t;

endpackage

// ==== verilog/limiter_if.sv ====
// Interfaces of the stream limiter
// sample_stream_if: valid/ready sample stream with user and last
// reg_bus_if: write strobe/ready register bus with combinational read
// limit_cfg_if: limits towards the datapath, clip pulses back

`timescale 1ns/100ps

interface sample_stream_if;
    import limiter_pkg::*;

    sample_t data;
    logic    user;
    logic    last;
    logic    valid;
    logic    ready;

    modport source (output data, output user, output last, output valid, input ready);
    modport sink (input data, input user, input last, input valid, output ready);
endinterface

interface reg_bus_if;
    import limiter_pkg::*;

    bus_addr_t address;
    bus_data_t write_data;
    logic      write_strobe;
    bus_data_t read_data;
    logic      ready;

    modport master (output address, output write_data, output write_strobe,
                    input read_data, input ready);
    modport slave (input address, input write_data, input write_strobe,
                   output read_data, output ready);
endinterface

interface limit_cfg_if;
    import limiter_pkg::*;

    sample_t limit_upper;
    sample_t limit_lower;
    logic    clip_high;
    logic    clip_low;

    modport provider (output limit_upper, output limit_lower, input clip_high, input clip_low);
    modport consumer (input limit_upper, input limit_lower, output clip_high, output clip_low);
endinterface

// ==== verilog/limiter_control.sv ====
// Register bus side of the stream limiter
// Two-state write handshake with latched offset and data
// Upper and lower limit registers
// Saturating clip counters, cleared by a write
// Combinational read multiplexer

`timescale 1ns/100ps
`include "limiter_params.svh"

module limiter_control (
    input  logic          clock,
    input  logic          reset,
    reg_bus_if.slave      bus,
    limit_cfg_if.provider cfg
);
    import limiter_pkg::*;

    bus_state_t  state;
    logic        act_done;
    bus_addr_t   latched_offset;
    bus_data_t   latched_data;
    sample_t     limit_upper;
    sample_t     limit_lower;
    clip_count_t clip_high_count;
    clip_count_t clip_low_count;
    bus_addr_t   read_offset;
    logic        write_accept;
    logic        commit;
    logic        clear_high;
    logic        clear_low;

    assign write_accept = bus.write_strobe && bus.ready && (state == IDLE);

    // Second ACT cycle applies the write
    assign commit = (state == ACT) && act_done;

    assign clear_high = commit && (latched_offset == `LIM_REG_CLIP_HIGH);
    assign clear_low  = commit && (latched_offset == `LIM_REG_CLIP_LOW);

    // Offset and data of an accepted write
    always_ff @(posedge clock) begin
        if (write_accept) begin
            latched_offset <= bus.address - bus_addr_t'(`LIM_BASE_ADDRESS);
            latched_data   <= bus.write_data;
        end
    end

    // Handshake state machine, ready low for two cycles per write
    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= IDLE;
            act_done  <= 1'b0;
            bus.ready <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    act_done <= 1'b0;
                    if (write_accept) begin
                        state     <= ACT;
                        bus.ready <= 1'b0;
                    end
                end
                ACT: begin
                    if (act_done) begin
                        state     <= IDLE;
                        bus.ready <= 1'b1;
                    end else begin
                        act_done <= 1'b1;
                    end
                end
                default: begin
                    state     <= IDLE;
                    bus.ready <= 1'b1;
                end
            endcase
        end
    end

    // Limit registers, unknown offsets ignored
    always_ff @(posedge clock) begin
        if (!reset) begin
            limit_upper <= '1;
            limit_lower <= '0;
        end else if (commit) begin
            case (latched_offset)
                `LIM_REG_UPPER: limit_upper <= sample_t'(latched_data);
                `LIM_REG_LOWER: limit_lower <= sample_t'(latched_data);
                default: ;
            endcase
        end
    end

    // Clip counters saturate, a clear beats a pulse
    always_ff @(posedge clock) begin
        if (!reset) begin
            clip_high_count <= '0;
            clip_low_count  <= '0;
        end else begin
            if (clear_high) begin
                clip_high_count <= '0;
            end else if (cfg.clip_high && (clip_high_count != '1)) begin
                clip_high_count <= clip_high_count + 1'b1;
            end
            if (clear_low) begin
                clip_low_count <= '0;
            end else if (cfg.clip_low && (clip_low_count != '1)) begin
                clip_low_count <= clip_low_count + 1'b1;
            end
        end
    end

    assign cfg.limit_upper = limit_upper;
    assign cfg.limit_lower = limit_lower;

    // Read data follows the address
    assign read_offset = bus.address - bus_addr_t'(`LIM_BASE_ADDRESS);

    always_comb begin
        case (read_offset)
            `LIM_REG_UPPER:     bus.read_data = bus_data_t'(limit_upper);
            `LIM_REG_LOWER:     bus.read_data = bus_data_t'(limit_lower);
            `LIM_REG_CLIP_HIGH: bus.read_data = bus_data_t'(clip_high_count);
            `LIM_REG_CLIP_LOW:  bus.read_data = bus_data_t'(clip_low_count);
            default:            bus.read_data = '0;
        endcase
    end

endmodule

// ==== verilog/limiter_datapath.sv ====
// Clamp stage of the stream limiter
// Upper limit checked first, then the lower one
// One-entry output register held under back-pressure
// Clip event pulses towards the counters

`timescale 1ns/100ps

module limiter_datapath (
    input  logic            clock,
    input  logic            reset,
    sample_stream_if.sink   in_stream,
    sample_stream_if.source out_stream,
    limit_cfg_if.consumer   cfg
);
    import limiter_pkg::*;

    logic    accept;
    logic    above;
    logic    below;
    sample_t clamped;

    // Refill when the output drains or is empty
    assign in_stream.ready = out_stream.ready || !out_stream.valid;
    assign accept = in_stream.valid && in_stream.ready;

    // Upper comparison takes precedence
    assign above = in_stream.data > cfg.limit_upper;
    assign below = !above && (in_stream.data < cfg.limit_lower);

    always_comb begin
        if (above) begin
            clamped = cfg.limit_upper;
        end else if (below) begin
            clamped = cfg.limit_lower;
        end else begin
            clamped = in_stream.data;
        end
    end

    // Output valid and clip pulses
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_stream.valid <= 1'b0;
            cfg.clip_high    <= 1'b0;
            cfg.clip_low     <= 1'b0;
        end else begin
            cfg.clip_high <= accept && above;
            cfg.clip_low  <= accept && below;
            if (accept) begin
                out_stream.valid <= 1'b1;
            end else if (out_stream.ready) begin
                out_stream.valid <= 1'b0;
            end
        end
    end

    // Payload only moves on acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            out_stream.data <= clamped;
            out_stream.user <= in_stream.user;
            out_stream.last <= in_stream.last;
        end
    end

endmodule

// ==== verilog/stream_limiter_top.sv ====
// Stream limiter top level
// Plain stream and register bus ports
// Interface instances between the control and datapath blocks

`timescale 1ns/100ps

module stream_limiter_top (
    input  logic                  clock,
    input  logic                  reset,

    // Input sample stream
    input  limiter_pkg::sample_t  in_data,
    input  logic                  in_user,
    input  logic                  in_last,
    input  logic                  in_valid,
    output logic                  in_ready,

    // Output sample stream
    output limiter_pkg::sample_t  out_data,
    output logic                  out_user,
    output logic                  out_last,
    output logic                  out_valid,
    input  logic                  out_ready,

    // Register bus
    input  limiter_pkg::bus_addr_t bus_address,
    input  limiter_pkg::bus_data_t bus_write_data,
    input  logic                   bus_write_strobe,
    output limiter_pkg::bus_data_t bus_read_data,
    output logic                   bus_ready
);

    sample_stream_if in_stream();
    sample_stream_if out_stream();
    reg_bus_if       bus();
    limit_cfg_if     cfg();

    assign in_stream.data  = in_data;
    assign in_stream.user  = in_user;
    assign in_stream.last  = in_last;
    assign in_stream.valid = in_valid;
    assign in_ready        = in_stream.ready;

    assign out_data         = out_stream.data;
    assign out_user         = out_stream.user;
    assign out_last         = out_stream.last;
    assign out_valid        = out_stream.valid;
    assign out_stream.ready = out_ready;

    assign bus.address      = bus_address;
    assign bus.write_data   = bus_write_data;
    assign bus.write_strobe = bus_write_strobe;
    assign bus_read_data    = bus.read_data;
    assign bus_ready        = bus.ready;

    // Limits and clip counters
    limiter_control control_i (
        .clock (clock),
        .reset (reset),
        .bus   (bus.slave),
        .cfg   (cfg.provider)
    );

    // Clamp stage
    limiter_datapath datapath_i (
        .clock      (clock),
        .reset      (reset),
        .in_stream  (in_stream.sink),
        .out_stream (out_stream.source),
        .cfg        (cfg.consumer)
    );

endmodule

// ==== tb/stream_limiter_assertions.sv ====
// Protocol assertions for the stream limiter datapath
// Output held under back-pressure, output empty after reset
// Exclusive clip pulses, input ready derived from the output register

`timescale 1ns/100ps

module stream_limiter_assertions (
    input logic                 clock,
    input logic                 reset,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input limiter_pkg::sample_t out_data,
    input logic                 out_user,
    input logic                 out_last,
    input logic                 clip_high,
    input logic                 clip_low
);

    // A stalled output keeps its payload and stays valid
    held_output_stable: assert property (
        @(posedge clock) disable iff (!reset)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_data) && $stable(out_user) && $stable(out_last))
    ) else $error("output payload changed while stalled");

    // Output register empty after a reset cycle
    empty_after_reset: assert property (
        @(posedge clock)
        !reset |=> !out_valid
    ) else $error("out_valid high after reset");

    // A sample clips at most one way
    exclusive_clip: assert property (
        @(posedge clock) disable iff (!reset)
        !(clip_high && clip_low)
    ) else $error("clip_high and clip_low high together");

    // Refill while draining or empty
    input_ready_rule: assert property (
        @(posedge clock) disable iff (!reset)
        in_ready == (out_ready || !out_valid)
    ) else $error("in_ready does not follow out_ready and out_valid");

endmodule

// ==== tb/stream_limiter_tb.sv ====
// Testbench for the stream limiter
// Clock, reset, register bus and stream stimulus
// Queue model of the clamp rule, checked by immediate assertions
// Per-test report lines and a closing count line

`timescale 1ns/100ps
`include "limiter_params.svh"

module stream_limiter_tb;
    import limiter_pkg::*;

    localparam int timeout_cycles = 1000;

    logic      clock;
    logic      reset;
    sample_t   in_data;
    logic      in_user;
    logic      in_last;
    logic      in_valid;
    logic      in_ready;
    sample_t   out_data;
    logic      out_user;
    logic      out_last;
    logic      out_valid;
    logic      out_ready;
    bus_addr_t bus_address;
    bus_data_t bus_write_data;
    logic      bus_write_strobe;
    bus_data_t bus_read_data;
    logic      bus_ready;

    // Reference model state
    logic [`LIM_DATA_WIDTH+1:0] expected_q[$];
    logic [`LIM_DATA_WIDTH+1:0] expected;
    sample_t model_upper;
    sample_t model_lower;
    int      model_high;
    int      model_low;

    // Monitor history and bookkeeping
    logic    accept_seen;
    logic    held_seen;
    sample_t held_data;
    logic    held_user;
    logic    held_last;
    logic    random_ready;
    integer  seed;
    int      checks;
    int      errors;
    int      start_checks;
    int      start_errors;

    stream_limiter_top dut_i (
        .clock            (clock),
        .reset            (reset),
        .in_data          (in_data),
        .in_user          (in_user),
        .in_last          (in_last),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .out_data         (out_data),
        .out_user         (out_user),
        .out_last         (out_last),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_strobe (bus_write_strobe),
        .bus_read_data    (bus_read_data),
        .bus_ready        (bus_ready)
    );

    bind limiter_datapath stream_limiter_assertions assertions_i (
        .clock     (clock),
        .reset     (reset),
        .in_ready  (in_stream.ready),
        .out_valid (out_stream.valid),
        .out_ready (out_stream.ready),
        .out_data  (out_stream.data),
        .out_user  (out_stream.user),
        .out_last  (out_stream.last),
        .clip_high (cfg.clip_high),
        .clip_low  (cfg.clip_low)
    );

    always #20 clock = ~clock;

    // Clamp rule, upper limit first
    function automatic sample_t clamp_model(input sample_t s, input sample_t up,
                                            input sample_t low);
        if (s > up) begin
            return up;
        end
        if (s < low) begin
            return low;
        end
        return s;
    endfunction

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("FAIL %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Falling edge, new out_ready
    task automatic next_cycle();
        @(negedge clock);
        out_ready = random_ready ? (($random(seed) % 2) != 0) : 1'b1;
    endtask

    task automatic begin_test();
        start_checks = checks;
        start_errors = errors;
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - start_checks,
                 errors - start_errors);
    endtask

    task automatic wait_bus_ready();
        int waited;
        waited = 0;
        while (!bus_ready) begin
            if (waited == timeout_cycles) begin
                stop_on_timeout("bus ready");
            end
            waited++;
            next_cycle();
        end
    endtask

    task automatic bus_write(input bus_data_t offset, input bus_data_t value);
        int low_cycles;
        wait_bus_ready();
        bus_address      = `LIM_BASE_ADDRESS + offset;
        bus_write_data   = value;
        bus_write_strobe = 1'b1;
        next_cycle();
        bus_write_strobe = 1'b0;
        low_cycles = 0;
        while (!bus_ready) begin
            if (low_cycles == timeout_cycles) begin
                stop_on_timeout("bus ready after a write");
            end
            low_cycles++;
            next_cycle();
        end
        check(low_cycles == 2, $sformatf("bus ready low for %0d cycles, expected 2",
                                         low_cycles));
        // The write has taken effect by now
        if (offset == `LIM_REG_UPPER) model_upper = value;
        if (offset == `LIM_REG_LOWER) model_lower = value;
        if (offset == `LIM_REG_CLIP_HIGH) model_high = 0;
        if (offset == `LIM_REG_CLIP_LOW) model_low = 0;
    endtask

    task automatic expect_register(input bus_data_t offset, input bus_data_t value,
                                   input string what);
        wait_bus_ready();
        bus_address = `LIM_BASE_ADDRESS + offset;
        next_cycle();
        check(bus_read_data == value, $sformatf("%s read %h, expected %h", what,
                                                bus_read_data, value));
    endtask

    task automatic send_sample(input sample_t value, input logic user, input logic last);
        int waited;
        waited = 0;
        in_data  = value;
        in_user  = user;
        in_last  = last;
        in_valid = 1'b1;
        #2;
        while (!in_ready) begin
            if (waited == timeout_cycles) begin
                stop_on_timeout("in_ready");
            end
            waited++;
            next_cycle();
            #2;
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    // A range of 0 means the full sample range
    task automatic send_random(input int count, input int range);
        logic [31:0] bits;
        sample_t     value;
        for (int i = 0; i < count; i++) begin
            value = $random(seed);
            if (range > 0) begin
                value = value % range;
            end
            bits = $random(seed);
            send_sample(value, bits[0], bits[1]);
        end
    endtask

    task automatic send_known();
        sample_t values[8];
        values = '{32'd50, 32'd2000, 32'd500, 32'd99, 32'd1001, 32'd1000, 32'd100, 32'd0};
        foreach (values[i]) begin
            send_sample(values[i], (i % 2) == 1, i == 7);
        end
    endtask

    task automatic drain_stream();
        int waited;
        waited = 0;
        #2;
        while (expected_q.size() != 0 || out_valid) begin
            if (waited == timeout_cycles) begin
                stop_on_timeout("the output stream to drain");
            end
            waited++;
            next_cycle();
            #2;
        end
        next_cycle();
    endtask

    // Looks one ns after the falling edge at the transfers of the next edge
    always begin
        @(negedge clock);
        #1;
        if (reset) begin
            if (accept_seen) begin
                check(out_valid, "out_valid missing one cycle after acceptance");
            end
            if (held_seen) begin
                check(out_data == held_data && out_user == held_user &&
                      out_last == held_last, "held output changed under back-pressure");
            end
            // Refill allowed while draining or with nothing held
            check(in_ready == (out_ready || expected_q.size() == 0),
                  $sformatf("in_ready %b with out_ready %b and %0d samples held",
                            in_ready, out_ready, expected_q.size()));
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    check(1'b0, "output transfer with no sample pending");
                end else begin
                    expected = expected_q.pop_front();
                    check({out_user, out_last, out_data} == expected,
                          $sformatf("output %h, expected %h",
                                    {out_user, out_last, out_data}, expected));
                end
            end
            accept_seen = in_valid && in_ready;
            if (accept_seen) begin
                expected_q.push_back({in_user, in_last,
                                      clamp_model(in_data, model_upper, model_lower)});
                if (in_data > model_upper) begin
                    model_high++;
                end else if (in_data < model_lower) begin
                    model_low++;
                end
            end
            held_seen = out_valid && !out_ready;
            held_data = out_data;
            held_user = out_user;
            held_last = out_last;
        end
    end

    initial begin
        seed             = 32'h27d2_738b;
        clock            = 1'b0;
        reset            = 1'b0;
        in_data          = '0;
        in_user          = 1'b0;
        in_last          = 1'b0;
        in_valid         = 1'b0;
        out_ready        = 1'b1;
        bus_address      = `LIM_BASE_ADDRESS;
        bus_write_data   = '0;
        bus_write_strobe = 1'b0;
        random_ready     = 1'b0;
        accept_seen      = 1'b0;
        held_seen        = 1'b0;
        model_upper      = '1;
        model_lower      = '0;
        model_high       = 0;
        model_low        = 0;
        checks           = 0;
        errors           = 0;
        repeat (2) next_cycle();
        reset = 1'b1;
        next_cycle();

        begin_test();
        expect_register(`LIM_REG_UPPER, 32'hffff_ffff, "upper limit");
        expect_register(`LIM_REG_LOWER, 32'h0, "lower limit");
        expect_register(`LIM_REG_CLIP_HIGH, 32'h0, "high clip count");
        expect_register(`LIM_REG_CLIP_LOW, 32'h0, "low clip count");
        send_random(8, 0);
        drain_stream();
        finish_test("reset values");

        begin_test();
        bus_write(`LIM_REG_UPPER, 32'd1000);
        bus_write(`LIM_REG_LOWER, 32'd100);
        send_random(40, 1200);
        send_random(10, 0);
        drain_stream();
        finish_test("clamping");

        begin_test();
        random_ready = 1'b1;
        send_random(60, 1200);
        drain_stream();
        random_ready = 1'b0;
        finish_test("back-pressure");

        // New upper limit for every sample after the write
        begin_test();
        bus_write(`LIM_REG_UPPER, 32'd500);
        expect_register(`LIM_REG_UPPER, 32'd500, "upper limit");
        send_random(16, 1000);
        drain_stream();
        finish_test("bus handshake");

        begin_test();
        bus_write(`LIM_REG_UPPER, 32'd1000);
        bus_write(`LIM_REG_CLIP_HIGH, 32'h0);
        bus_write(`LIM_REG_CLIP_LOW, 32'h0);
        send_known();
        drain_stream();
        expect_register(`LIM_REG_CLIP_HIGH, bus_data_t'(model_high), "high clip count");
        expect_register(`LIM_REG_CLIP_LOW, bus_data_t'(model_low), "low clip count");
        bus_write(`LIM_REG_CLIP_HIGH, 32'h0);
        expect_register(`LIM_REG_CLIP_HIGH, 32'h0, "cleared high clip count");
        expect_register(`LIM_REG_CLIP_LOW, bus_data_t'(model_low), "low clip count");
        bus_write(`LIM_REG_CLIP_LOW, 32'h0);
        expect_register(`LIM_REG_CLIP_LOW, 32'h0, "cleared low clip count");
        finish_test("clip counters");

        begin_test();
        bus_write(`LIM_REG_UPPER, 32'd200);
        bus_write(`LIM_REG_LOWER, 32'd800);
        send_random(30, 1000);
        drain_stream();
        finish_test("inverted limits");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/limiter_pkg.sv
verilog/limiter_if.sv
verilog/limiter_control.sv
verilog/limiter_datapath.sv
verilog/stream_limiter_top.sv
tb/stream_limiter_assertions.sv
tb/stream_limiter_tb.sv

// ==== Makefile ====
# Verilator flow for the stream limiter
#   make lint   check the sources
#   make sim    build and run the testbench
#   make clean  remove build output

TOP = stream_limiter_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

# The run passes only if the pass message shows up in the output
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
